// ==== design/kd_tree_pkg.sv ====
// --------------------------------------------------------------------
// kd tree geometry
// depth of the internal node tree and the layout of one node word
// --------------------------------------------------------------------
package kd_tree_pkg;

    // levels of internal nodes, root is level 0
    parameter int TREE_DEPTH = 6;

    // node word, median in the upper half, component select below
    parameter int SPLIT_IDX_WIDTH = 11;
    parameter int MEDIAN_WIDTH    = 11;
    parameter int NODE_WIDTH      = SPLIT_IDX_WIDTH + MEDIAN_WIDTH;

    // one bit per left/right choice on the way down
    parameter int LEAF_IDX_WIDTH = 6;

    // breadth-first write counter
    // 63 nodes fit, the top count selects nothing
    parameter int LOAD_ADDR_WIDTH = 6;

endpackage

// ==== design/kd_patch_pkg.sv ====
// --------------------------------------------------------------------
// image patch layout
// five unsigned components packed side by side, component 0 lowest
// --------------------------------------------------------------------
package kd_patch_pkg;

    // one unsigned component
    parameter int COMPONENT_WIDTH = 11;

    // components per patch
    parameter int NUM_COMPONENTS = 5;

    // component k sits at bits 11k+10 down to 11k
    parameter int PATCH_WIDTH = COMPONENT_WIDTH * NUM_COMPONENTS;

endpackage

// ==== design/node_loader.sv ====
// --------------------------------------------------------------------
// node table loader
// breadth-first write counter plus one-hot write decode, one enable
// per internal node, active only while both load strobes are high
// --------------------------------------------------------------------
`timescale 1ns/1ps

module node_loader (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          fsm_enable_i,
    input  logic                                          sender_en_i,
    output logic [(2**kd_tree_pkg::LOAD_ADDR_WIDTH)-2:0]  node_wen_o
);

    localparam int AW        = kd_tree_pkg::LOAD_ADDR_WIDTH;
    localparam int NUM_NODES = (2**AW) - 1;

    logic [AW-1:0] wadr_q;
    logic          load_en;

    // a word is taken only with both strobes
    assign load_en = fsm_enable_i & sender_en_i;

    // counter wraps 63 -> 0 on its own
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wadr_q <= '0;
        end else if (load_en) begin
            wadr_q <= wadr_q + 1'b1;
        end
    end

    // address 63 has no bit here, so it writes nothing
    always_comb begin
        for (int n = 0; n < NUM_NODES; n++) begin
            node_wen_o[n] = load_en && (wadr_q == AW'(n));
        end
    end

endmodule

// ==== design/kd_internal_node.sv ====
// --------------------------------------------------------------------
// kd tree internal node
// holds one node word and steers each of the two patch streams
// left or right by comparing the selected component to the median
// --------------------------------------------------------------------
`timescale 1ns/1ps

module kd_internal_node #(
    parameter int NODE_W = kd_tree_pkg::NODE_WIDTH
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  wen_i,
    input  logic [NODE_W-1:0]                     wdata_i,
    input  logic [kd_patch_pkg::PATCH_WIDTH-1:0]  patch_i,
    input  logic                                  valid_i,
    input  logic [kd_patch_pkg::PATCH_WIDTH-1:0]  patch_two_i,
    input  logic                                  valid_two_i,
    output logic                                  valid_left_o,
    output logic                                  valid_right_o,
    output logic                                  valid_left_two_o,
    output logic                                  valid_right_two_o
);

    localparam int SW = kd_tree_pkg::SPLIT_IDX_WIDTH;
    localparam int MW = kd_tree_pkg::MEDIAN_WIDTH;
    localparam int CW = kd_patch_pkg::COMPONENT_WIDTH;

    logic [NODE_W-1:0] node_q;
    logic [SW-1:0]     split_idx;
    logic [MW-1:0]     median;
    logic              go_left;
    logic              go_left_two;

    // out-of-range select falls back to component 0
    function automatic logic [CW-1:0] pick_component(
        input logic [kd_patch_pkg::PATCH_WIDTH-1:0] patch,
        input logic [SW-1:0]                        idx
    );
        logic [CW-1:0] comp;
        comp = patch[CW-1:0];
        for (int k = 1; k < kd_patch_pkg::NUM_COMPONENTS; k++) begin
            if (idx == SW'(k)) begin
                comp = patch[k*CW +: CW];
            end
        end
        return comp;
    endfunction

    // node word, written by the loader
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            node_q <= '0;
        end else if (wen_i) begin
            node_q <= wdata_i;
        end
    end

    assign split_idx = node_q[SW-1:0];
    assign median    = node_q[SW +: MW];

    // strictly below the median goes left, equal goes right
    assign go_left     = pick_component(patch_i, split_idx) < median;
    assign go_left_two = pick_component(patch_two_i, split_idx) < median;

    assign valid_left_o      = valid_i & go_left;
    assign valid_right_o     = valid_i & ~go_left;
    assign valid_left_two_o  = valid_two_i & go_left_two;
    assign valid_right_two_o = valid_two_i & ~go_left_two;

endmodule

// ==== design/kd_tree_level.sv ====
// --------------------------------------------------------------------
// kd tree pipeline level
// the 2^LEVEL nodes of one tree level plus the stage registers for
// patch, enable and one-hot position of both streams
// --------------------------------------------------------------------
`timescale 1ns/1ps

module kd_tree_level #(
    parameter int LEVEL = 0
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [(2**LEVEL)-1:0]                 node_wen_i,
    input  logic [kd_tree_pkg::NODE_WIDTH-1:0]    wdata_i,
    input  logic [kd_patch_pkg::PATCH_WIDTH-1:0]  patch_i,
    input  logic                                  patch_en_i,
    input  logic [(2**LEVEL)-1:0]                 onehot_i,
    input  logic [kd_patch_pkg::PATCH_WIDTH-1:0]  patch_two_i,
    input  logic                                  patch_two_en_i,
    input  logic [(2**LEVEL)-1:0]                 onehot_two_i,
    output logic [kd_patch_pkg::PATCH_WIDTH-1:0]  patch_o,
    output logic                                  patch_en_o,
    output logic [(2**(LEVEL+1))-1:0]             onehot_o,
    output logic [kd_patch_pkg::PATCH_WIDTH-1:0]  patch_two_o,
    output logic                                  patch_two_en_o,
    output logic [(2**(LEVEL+1))-1:0]             onehot_two_o
);

    localparam int NODES = 2**LEVEL;

    // child positions, node j feeds bits 2j (left) and 2j+1 (right)
    logic [2*NODES-1:0] next_oh;
    logic [2*NODES-1:0] next_oh_two;

    for (genvar j = 0; j < NODES; j++) begin : g_node
        kd_internal_node #(
            .NODE_W(kd_tree_pkg::NODE_WIDTH)
        ) node_i (
            .clk              (clk),
            .rst_n            (rst_n),
            .wen_i            (node_wen_i[j]),
            .wdata_i          (wdata_i),
            .patch_i          (patch_i),
            .valid_i          (onehot_i[j]),
            .patch_two_i      (patch_two_i),
            .valid_two_i      (onehot_two_i[j]),
            .valid_left_o     (next_oh[2*j]),
            .valid_right_o    (next_oh[2*j+1]),
            .valid_left_two_o (next_oh_two[2*j]),
            .valid_right_two_o(next_oh_two[2*j+1])
        );
    end

    // position and enable per stream
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            patch_en_o     <= 1'b0;
            patch_two_en_o <= 1'b0;
            onehot_o       <= '0;
            onehot_two_o   <= '0;
        end else begin
            patch_en_o     <= patch_en_i;
            patch_two_en_o <= patch_two_en_i;
            onehot_o       <= next_oh;
            onehot_two_o   <= next_oh_two;
        end
    end

    // patch payload just follows along
    always_ff @(posedge clk) begin
        patch_o     <= patch_i;
        patch_two_o <= patch_two_i;
    end

endmodule

// ==== design/leaf_index_encoder.sv ====
// --------------------------------------------------------------------
// leaf index encoder
// one-hot leaf position of each stream to a registered binary index
// with its receiver strobe, index held at zero without a patch
// --------------------------------------------------------------------
`timescale 1ns/1ps

module leaf_index_encoder #(
    parameter int LEAF_W = kd_tree_pkg::LEAF_IDX_WIDTH
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [(2**LEAF_W)-1:0]   onehot_i,
    input  logic [(2**LEAF_W)-1:0]   onehot_two_i,
    input  logic                     patch_en_i,
    input  logic                     patch_two_en_i,
    output logic [LEAF_W-1:0]        leaf_index_o,
    output logic [LEAF_W-1:0]        leaf_index_two_o,
    output logic                     receiver_en_o,
    output logic                     receiver_two_en_o
);

    // ascending scan, so the highest set bit wins
    function automatic logic [LEAF_W-1:0] encode(input logic [(2**LEAF_W)-1:0] oh);
        logic [LEAF_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < 2**LEAF_W; i++) begin
            if (oh[i]) begin
                idx = LEAF_W'(i);
            end
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            receiver_en_o     <= 1'b0;
            receiver_two_en_o <= 1'b0;
            leaf_index_o      <= '0;
            leaf_index_two_o  <= '0;
        end else begin
            receiver_en_o     <= patch_en_i;
            receiver_two_en_o <= patch_two_en_i;
            leaf_index_o      <= patch_en_i ? encode(onehot_i) : '0;
            leaf_index_two_o  <= patch_two_en_i ? encode(onehot_two_i) : '0;
        end
    end

endmodule

// ==== design/kd_internal_node_tree.sv ====
// --------------------------------------------------------------------
// kd tree search top level
// input registers, node loader, DEPTH pipelined tree levels and the
// leaf encoder for two independent patch streams
// --------------------------------------------------------------------
`timescale 1ns/1ps

module kd_internal_node_tree #(
    parameter int DEPTH = kd_tree_pkg::TREE_DEPTH
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  fsm_enable_i,
    input  logic                                  sender_en_i,
    input  logic [kd_tree_pkg::NODE_WIDTH-1:0]    sender_data_i,
    input  logic                                  patch_en_i,
    input  logic [kd_patch_pkg::PATCH_WIDTH-1:0]  patch_i,
    input  logic                                  patch_two_en_i,
    input  logic [kd_patch_pkg::PATCH_WIDTH-1:0]  patch_two_i,
    output logic [DEPTH-1:0]                      leaf_index_o,
    output logic                                  receiver_en_o,
    output logic [DEPTH-1:0]                      leaf_index_two_o,
    output logic                                  receiver_two_en_o
);

    localparam int PW        = kd_patch_pkg::PATCH_WIDTH;
    localparam int LEAVES    = 2**DEPTH;
    localparam int NUM_NODES = (2**kd_tree_pkg::LOAD_ADDR_WIDTH) - 1;

    logic [NUM_NODES-1:0] node_wen;
    logic [PW-1:0]        patch_q;
    logic [PW-1:0]        patch_two_q;
    logic                 patch_en_q;
    logic                 patch_two_en_q;

    // stage s is the input of level s, stage DEPTH feeds the encoder
    wire [PW-1:0]     stage_patch     [0:DEPTH];
    wire [PW-1:0]     stage_patch_two [0:DEPTH];
    wire              stage_en        [0:DEPTH];
    wire              stage_en_two    [0:DEPTH];
    wire [LEAVES-1:0] stage_oh        [0:DEPTH];
    wire [LEAVES-1:0] stage_oh_two    [0:DEPTH];

    node_loader loader_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fsm_enable_i(fsm_enable_i),
        .sender_en_i (sender_en_i),
        .node_wen_o  (node_wen)
    );

    // input registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            patch_en_q     <= 1'b0;
            patch_two_en_q <= 1'b0;
        end else begin
            patch_en_q     <= patch_en_i;
            patch_two_en_q <= patch_two_en_i;
        end
    end

    always_ff @(posedge clk) begin
        patch_q     <= patch_i;
        patch_two_q <= patch_two_i;
    end

    // root bit of the one-hot is the registered enable itself
    assign stage_patch[0]     = patch_q;
    assign stage_patch_two[0] = patch_two_q;
    assign stage_en[0]        = patch_en_q;
    assign stage_en_two[0]    = patch_two_en_q;
    assign stage_oh[0]        = LEAVES'(patch_en_q);
    assign stage_oh_two[0]    = LEAVES'(patch_two_en_q);

    for (genvar l = 0; l < DEPTH; l++) begin : g_level
        // level l owns nodes 2^l-1 .. 2^(l+1)-2
        kd_tree_level #(
            .LEVEL(l)
        ) level_i (
            .clk           (clk),
            .rst_n         (rst_n),
            .node_wen_i    (node_wen[(2**(l+1))-2 : (2**l)-1]),
            .wdata_i       (sender_data_i),
            .patch_i       (stage_patch[l]),
            .patch_en_i    (stage_en[l]),
            .onehot_i      (stage_oh[l][(2**l)-1:0]),
            .patch_two_i   (stage_patch_two[l]),
            .patch_two_en_i(stage_en_two[l]),
            .onehot_two_i  (stage_oh_two[l][(2**l)-1:0]),
            .patch_o       (stage_patch[l+1]),
            .patch_en_o    (stage_en[l+1]),
            .onehot_o      (stage_oh[l+1][(2**(l+1))-1:0]),
            .patch_two_o   (stage_patch_two[l+1]),
            .patch_two_en_o(stage_en_two[l+1]),
            .onehot_two_o  (stage_oh_two[l+1][(2**(l+1))-1:0])
        );

        // positions not reachable yet at this depth
        if (l + 1 < DEPTH) begin : g_pad
            assign stage_oh[l+1][LEAVES-1:2**(l+1)]     = '0;
            assign stage_oh_two[l+1][LEAVES-1:2**(l+1)] = '0;
        end
    end

    leaf_index_encoder #(
        .LEAF_W(DEPTH)
    ) encoder_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .onehot_i         (stage_oh[DEPTH]),
        .onehot_two_i     (stage_oh_two[DEPTH]),
        .patch_en_i       (stage_en[DEPTH]),
        .patch_two_en_i   (stage_en_two[DEPTH]),
        .leaf_index_o     (leaf_index_o),
        .leaf_index_two_o (leaf_index_two_o),
        .receiver_en_o    (receiver_en_o),
        .receiver_two_en_o(receiver_two_en_o)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
// --------------------------------------------------------------------
// testbench clock and reset
// free running clock, reset held low for a few cycles at start
// --------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// ==== sim/kd_tree_tb.sv ====
// --------------------------------------------------------------------
// kd tree search testbench
// loads the node table and runs patch records from the input file,
// comparing each stream's leaf and strobe with the file's values
// --------------------------------------------------------------------
`timescale 1ns/1ps

module kd_tree_tb;

    localparam int PW           = kd_patch_pkg::PATCH_WIDTH;
    localparam int CW           = kd_patch_pkg::COMPONENT_WIDTH;
    localparam int NC           = kd_patch_pkg::NUM_COMPONENTS;
    localparam int NW           = kd_tree_pkg::NODE_WIDTH;
    localparam int SW           = kd_tree_pkg::SPLIT_IDX_WIDTH;
    localparam int MW           = kd_tree_pkg::MEDIAN_WIDTH;
    localparam int LW           = kd_tree_pkg::LEAF_IDX_WIDTH;
    localparam int RESET_CYCLES = 2;
    localparam int MAX_REC      = 256;
    // driven after edge n, sampled at n+1, seven more edges to the output
    localparam int LATENCY      = 8;

    logic          clk;
    logic          rst_n;
    logic          fsm_enable;
    logic          sender_en;
    logic [NW-1:0] sender_data;
    logic          patch_en;
    logic [PW-1:0] patch;
    logic          patch_two_en;
    logic [PW-1:0] patch_two;
    logic [LW-1:0] leaf_index;
    logic          receiver_en;
    logic [LW-1:0] leaf_index_two;
    logic          receiver_two_en;

    // records from the data file
    byte rec_kind [0:MAX_REC-1];
    int  rec_f    [0:MAX_REC-1][0:13];
    int  num_rec  = 0;

    int cycles = 0;
    int limit  = 0;
    int errors = 0;
    int checks = 0;

    // due cycle and leaf of each patch in flight, per stream
    int due_q[$];
    int leaf_q[$];
    int due_two_q[$];
    int leaf_two_q[$];

    tb_clock_gen #(
        .PERIOD_NS   (10),
        .RESET_CYCLES(RESET_CYCLES)
    ) clock_gen_i (
        .clk_o  (clk),
        .rst_n_o(rst_n)
    );

    kd_internal_node_tree #(
        .DEPTH(kd_tree_pkg::TREE_DEPTH)
    ) kd_internal_node_tree_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .fsm_enable_i     (fsm_enable),
        .sender_en_i      (sender_en),
        .sender_data_i    (sender_data),
        .patch_en_i       (patch_en),
        .patch_i          (patch),
        .patch_two_en_i   (patch_two_en),
        .patch_two_i      (patch_two),
        .leaf_index_o     (leaf_index),
        .receiver_en_o    (receiver_en),
        .leaf_index_two_o (leaf_index_two),
        .receiver_two_en_o(receiver_two_en)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // watchdog, limit comes from the record count
    always @(posedge clk) begin
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // five components of a record, component 0 in the low bits
    function automatic logic [PW-1:0] patch_from(input int r, input int first);
        logic [PW-1:0] p;
        p = '0;
        for (int k = 0; k < NC; k++) begin
            p[k*CW +: CW] = CW'(rec_f[r][first+k]);
        end
        return p;
    endfunction

    task automatic read_records(output bit ok);
        int    fd;
        int    n;
        int    want;
        int    line_no;
        int    f [0:13];
        byte   kind;
        string line;
        string rest;
        ok      = 1'b0;
        line_no = 0;
        fd      = $fopen("sim/kd_tree_input.txt", "r");
        if (fd == 0) begin
            return;
        end
        ok = 1'b1;
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            line_no++;
            if (n == 0 || line.len() == 0) begin
                continue;
            end
            kind = line.getc(0);
            // comment and blank lines
            if (kind == "#" || kind == "\n") begin
                continue;
            end
            f    = '{default: 0};
            rest = line.substr(1, line.len() - 1);
            if (kind == "L") begin
                n    = $sscanf(rest, "%d %d %d", f[0], f[1], f[2]);
                want = 3;
            end else if (kind == "P") begin
                n    = $sscanf(rest, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                               f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
                want = 14;
            end else if (kind == "I") begin
                n    = 0;
                want = 0;
            end else begin
                n    = -1;
                want = 0;
            end
            if (n != want || num_rec >= MAX_REC) begin
                errors++;
                $display("malformed or excess record on line %0d of the input file", line_no);
            end else begin
                rec_kind[num_rec] = kind;
                for (int k = 0; k < 14; k++) begin
                    rec_f[num_rec][k] = f[k];
                end
                num_rec++;
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_inputs();
        fsm_enable   = 1'b0;
        sender_en    = 1'b0;
        sender_data  = '0;
        patch_en     = 1'b0;
        patch        = '0;
        patch_two_en = 1'b0;
        patch_two    = '0;
    endtask

    task automatic apply_record(input int r);
        idle_inputs();
        case (rec_kind[r])
            "L": begin
                // sender strobe always high, fsm enable from the file
                fsm_enable  = (rec_f[r][0] != 0);
                sender_en   = 1'b1;
                sender_data = {MW'(rec_f[r][1]), SW'(rec_f[r][2])};
            end
            "P": begin
                patch_en     = (rec_f[r][0] != 0);
                patch        = patch_from(r, 1);
                patch_two_en = (rec_f[r][7] != 0);
                patch_two    = patch_from(r, 8);
                if (patch_en) begin
                    due_q.push_back(cycles + LATENCY);
                    leaf_q.push_back(rec_f[r][6]);
                end
                if (patch_two_en) begin
                    due_two_q.push_back(cycles + LATENCY);
                    leaf_two_q.push_back(rec_f[r][13]);
                end
            end
            default: ;
        endcase
    endtask

    task automatic compare_stream(
        input string         name,
        input logic          got_en,
        input logic [LW-1:0] got_leaf,
        input logic          exp_en,
        input logic [LW-1:0] exp_leaf
    );
        checks += 2;
        assert (got_en === exp_en) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s strobe is %b, expected %b",
                     $time, name, got_en, exp_en);
        end
        assert (got_leaf === exp_leaf) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s leaf is %0d, expected %0d",
                     $time, name, got_leaf, exp_leaf);
        end
    endtask

    // without a result due this cycle, strobe and index must be zero
    task automatic check_outputs();
        logic          exp_en;
        logic          exp_en_two;
        logic [LW-1:0] exp_leaf;
        logic [LW-1:0] exp_leaf_two;
        exp_en       = 1'b0;
        exp_en_two   = 1'b0;
        exp_leaf     = '0;
        exp_leaf_two = '0;
        if (due_q.size() != 0 && due_q[0] == cycles) begin
            exp_en   = 1'b1;
            exp_leaf = LW'(leaf_q[0]);
            void'(due_q.pop_front());
            void'(leaf_q.pop_front());
        end
        if (due_two_q.size() != 0 && due_two_q[0] == cycles) begin
            exp_en_two   = 1'b1;
            exp_leaf_two = LW'(leaf_two_q[0]);
            void'(due_two_q.pop_front());
            void'(leaf_two_q.pop_front());
        end
        compare_stream("stream one", receiver_en, leaf_index, exp_en, exp_leaf);
        compare_stream("stream two", receiver_two_en, leaf_index_two, exp_en_two, exp_leaf_two);
    endtask

    initial begin
        bit ok;
        idle_inputs();
        read_records(ok);
        if (!ok) begin
            $display("could not open sim/kd_tree_input.txt");
            $display("Testbench failed");
            $finish;
        end else begin
            limit = 2 * num_rec + 40;
            // outputs stay quiet through reset
            repeat (RESET_CYCLES) begin
                @(posedge clk);
                #1;
                check_outputs();
            end
            for (int r = 0; r < num_rec; r++) begin
                @(posedge clk);
                #1;
                check_outputs();
                apply_record(r);
            end
            // drain the pipeline, then a few empty cycles
            idle_inputs();
            while (due_q.size() != 0 || due_two_q.size() != 0) begin
                @(posedge clk);
                #1;
                check_outputs();
            end
            repeat (2) begin
                @(posedge clk);
                #1;
                check_outputs();
            end
            $display("errors: %0d, checks: %0d", errors, checks);
            if (errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

// ==== project.f ====
design/kd_tree_pkg.sv
design/kd_patch_pkg.sv
design/node_loader.sv
design/kd_internal_node.sv
design/kd_tree_level.sv
design/leaf_index_encoder.sv
design/kd_internal_node_tree.sv
sim/tb_clock_gen.sv
sim/kd_tree_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = kd_tree_tb
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/kd_tree_input.txt ====
# L fsm_enable median split   (one node word, breadth-first order)
# P en c0 c1 c2 c3 c4 leaf (stream one)  en c0 c1 c2 c3 c4 leaf (stream two)   I idle
# stray word with fsm enable low, must not be written
L 0 5 0
# levels 0 to 2: split on components 0, 1, 2
L 1 1000 0
L 1 500 1
L 1 508 1
L 1 400 2
L 1 408 2
L 1 416 2
L 1 424 2
# levels 3 and 4: split on components 3 and 4
L 1 300 3
L 1 308 3
L 1 316 3
L 1 324 3
L 1 332 3
L 1 340 3
L 1 348 3
L 1 356 3
L 1 200 4
L 1 208 4
L 1 216 4
L 1 224 4
L 1 232 4
L 1 240 4
L 1 248 4
L 1 256 4
L 1 264 4
L 1 272 4
L 1 280 4
L 1 288 4
L 1 296 4
L 1 304 4
L 1 312 4
L 1 320 4
# level 5: split 5 or 2047, both fall back to component 0
L 1 600 5
L 1 608 2047
L 1 616 5
L 1 624 2047
L 1 632 5
L 1 640 2047
L 1 648 5
L 1 656 2047
L 1 664 5
L 1 672 2047
L 1 680 5
L 1 688 2047
L 1 696 5
L 1 704 2047
L 1 712 5
L 1 720 2047
L 1 728 5
L 1 736 2047
L 1 744 5
L 1 752 2047
L 1 760 5
L 1 768 2047
L 1 776 5
L 1 784 2047
L 1 792 5
L 1 800 2047
L 1 808 5
L 1 816 2047
L 1 824 5
L 1 832 2047
L 1 840 5
L 1 848 2047
I
# single patches on stream one
P 1 0 0 0 0 0 0 0 0 0 0 0 0 0
I
P 1 2047 2047 2047 2047 2047 63 0 0 0 0 0 0 0
I
I
P 1 1000 508 423 348 303 53 0 0 0 0 0 0 0
I
# both streams, back to back, several components equal to a median
P 1 999 500 407 316 240 23 1 650 499 399 299 199 1
P 1 601 600 100 400 241 22 1 1500 100 416 339 2000 43
P 1 1200 509 0 2047 304 55 1 700 200 500 0 500 11
P 1 639 200 500 0 500 10 1 1100 2047 0 0 0 49
P 1 1999 507 410 330 260 33 1 300 501 408 320 255 26
P 1 300 501 408 320 255 26 1 1999 507 410 330 260 33
# gaps in the enables, disabled patches carry data that must not show
P 1 1100 2047 0 0 0 49 0 0 0 0 0 0 0
P 0 2047 2047 2047 2047 2047 0 1 0 0 0 0 0 0
P 1 650 499 399 299 199 1 0 1500 100 416 339 2000 0
I
P 1 1500 100 416 339 2000 43 1 2047 2047 2047 2047 2047 63
P 0 1000 508 423 348 303 0 0 999 500 407 316 240 0
P 1 601 600 100 400 241 22 1 1200 509 0 2047 304 55
I
